//--- design/memctrl_pkg.sv
// Block-RAM memory controller, shared definitions
// word, thread id and block address widths, the command and response
// words that cross the port boundary, the registered RAM request, the
// return tag that follows each issued beat, and the burst FSM states

`default_nettype none

package memctrl_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------

	// one RAM word
	localparam int DATA_W = 64;
	// thread id carried through to the response
	localparam int TID_W = 5;
	// cache block address, two words per block
	localparam int BLK_W = 10;
	// word address = block address plus beat bit
	localparam int ADDR_W = BLK_W + 1;
	// port field of the return tag, up to 8 ports
	localparam int TAG_PORT_W = 3;

	// --------------------------------------------------
	// port side words
	// --------------------------------------------------

	// one command word from a refill port
	typedef struct packed {
		logic              valid;
		logic              we;
		logic [TID_W-1:0]  tid;
		logic [BLK_W-1:0]  blk;
		logic [DATA_W-1:0] data;
	} mem_cmd_t;

	// one response beat back to a port
	typedef struct packed {
		// read data present
		logic              valid;
		// last beat of the block
		logic              done;
		logic [TID_W-1:0]  tid;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} mem_rsp_t;

	// --------------------------------------------------
	// internal words
	// --------------------------------------------------

	// RAM input register contents
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} ram_req_t;

	// return info riding alongside each issued beat
	typedef struct packed {
		// beat actually issued this slot
		logic                  live;
		logic                  rd;
		logic                  done;
		logic [TAG_PORT_W-1:0] port;
		logic [TID_W-1:0]      tid;
		logic [ADDR_W-1:0]     addr;
	} beat_tag_t;

	// two-beat burst FSM
	typedef enum logic {
		BURST_FIRST  = 1'b0,
		BURST_SECOND = 1'b1
	} burst_state_e;

endpackage

`default_nettype wire

//--- design/port_buffer.sv
// Port input buffer
// two-entry in-order queue in front of one refill port; the head entry
// is offered to the scheduler and dropped when consume is high, the
// second entry then slides up into the head slot

`timescale 1ns/1ps
`default_nettype none

module port_buffer import memctrl_pkg::*; (
	input  logic     gclk,
	input  logic     rst,
	input  mem_cmd_t cmd_in,
	input  logic     consume,
	output mem_cmd_t head
);

	// slot0 is the head, slot1 the waiting entry
	mem_cmd_t slot0, slot1;
	mem_cmd_t slot0_nxt, slot1_nxt;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		// pop first, the second entry moves up
		if (consume) begin
			slot0_nxt = slot1;
			slot1_nxt = slot1;
			slot1_nxt.valid = 1'b0;
		end else begin
			slot0_nxt = slot0;
			slot1_nxt = slot1;
		end
		// then drop the new command into the first free slot
		if (!slot0_nxt.valid) begin
			slot0_nxt = cmd_in;
		end else if (!slot1_nxt.valid) begin
			slot1_nxt = cmd_in;
		end
	end

	// payload always loads, only the valid bits see reset
	always_ff @(posedge gclk) begin
		slot0 <= slot0_nxt;
		slot1 <= slot1_nxt;
		if (rst) begin
			slot0.valid <= 1'b0;
			slot1.valid <= 1'b0;
		end
	end

	assign head = slot0;

	// requester sent without a credit: both slots busy, nothing leaving
	a_no_overflow: assert property (@(posedge gclk) disable iff (rst)
		!(cmd_in.valid && slot0.valid && slot1.valid && !consume))
		else $error("port_buffer overflow, command sent without credit");

endmodule

`default_nettype wire

//--- design/burst_scheduler.sv
// Burst scheduler
// round-robin picker with park over the port heads, and a two-state
// burst FSM that issues the even then the odd word of one block; each
// issued beat lands in the RAM input register and the return tag on
// the next edge, and every consume comes back one cycle later as credit

`timescale 1ns/1ps
`default_nettype none

module burst_scheduler import memctrl_pkg::*; #(
	parameter int N_PORTS = 4
) (
	input  logic               gclk,
	input  logic               rst,
	input  mem_cmd_t           heads [N_PORTS],
	output logic [N_PORTS-1:0] consume,
	output logic [N_PORTS-1:0] credit,
	output ram_req_t           ram_req,
	output beat_tag_t          beat_tag
);

	localparam int PORT_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

	burst_state_e      state, state_nxt;
	logic [PORT_W-1:0] cur_port, cur_nxt, next_port;
	logic [PORT_W-1:0] pick_hi, pick_lo;
	logic              has_hi, has_lo;
	logic              issue, beat;
	mem_cmd_t          head_cur;

	assign head_cur = heads[cur_port];

	// --------------------------------------------------
	// picker
	// --------------------------------------------------
	// first valid above current wins, else first valid at or below,
	// else stay parked
	always_comb begin
		has_hi = 1'b0;
		has_lo = 1'b0;
		pick_hi = '0;
		pick_lo = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (heads[i].valid && i > cur_port && !has_hi) begin
				has_hi = 1'b1;
				pick_hi = PORT_W'(i);
			end
			if (heads[i].valid && i <= cur_port && !has_lo) begin
				has_lo = 1'b1;
				pick_lo = PORT_W'(i);
			end
		end
		next_port = has_hi ? pick_hi : (has_lo ? pick_lo : cur_port);
	end

	// --------------------------------------------------
	// burst FSM
	// --------------------------------------------------
	always_comb begin
		state_nxt = state;
		cur_nxt = cur_port;
		consume = '0;
		issue = 1'b0;
		beat = 1'b0;
		case (state)
			BURST_FIRST: begin
				// even word, hold the port for the odd one
				if (head_cur.valid) begin
					issue = 1'b1;
					consume[cur_port] = 1'b1;
					state_nxt = BURST_SECOND;
				end else begin
					cur_nxt = next_port;
				end
			end
			BURST_SECOND: begin
				// odd word, then rotate
				issue = 1'b1;
				beat = 1'b1;
				consume[cur_port] = 1'b1;
				state_nxt = BURST_FIRST;
				cur_nxt = next_port;
			end
			default: state_nxt = BURST_FIRST;
		endcase
	end

	// RAM input register, return tag and credit
	always_ff @(posedge gclk) begin
		ram_req.addr <= {head_cur.blk, beat};
		ram_req.data <= head_cur.data;
		beat_tag.rd <= ~head_cur.we;
		beat_tag.done <= beat;
		beat_tag.port <= TAG_PORT_W'(cur_port);
		beat_tag.tid <= head_cur.tid;
		beat_tag.addr <= {head_cur.blk, beat};
		if (rst) begin
			state <= BURST_FIRST;
			cur_port <= '0;
			credit <= '0;
			ram_req.we <= 1'b0;
			beat_tag.live <= 1'b0;
		end else begin
			state <= state_nxt;
			cur_port <= cur_nxt;
			credit <= consume;
			ram_req.we <= issue & head_cur.we;
			beat_tag.live <= issue;
		end
	end

	// odd word must already sit behind the even one
	a_odd_present: assert property (@(posedge gclk) disable iff (rst)
		(state == BURST_SECOND) |-> heads[cur_port].valid)
		else $error("odd word of block missing on port %0d", cur_port);

endmodule

`default_nettype wire

//--- design/block_ram.sv
// Block RAM
// single-port synchronous word memory, one-cycle read latency,
// read-before-write so a write cycle returns the old word

`timescale 1ns/1ps
`default_nettype none

module block_ram import memctrl_pkg::*; (
	input  logic              gclk,
	input  ram_req_t          req,
	output logic [DATA_W-1:0] rdata
);

	localparam int DEPTH = 2 ** ADDR_W;

	// two words per block
	logic [DATA_W-1:0] mem [DEPTH];

	// --------------------------------------------------
	// port
	// --------------------------------------------------
	always_ff @(posedge gclk) begin
		if (req.we) begin
			mem[req.addr] <= req.data;
		end
		// old contents on a write
		rdata <= mem[req.addr];
	end

endmodule

`default_nettype wire

//--- design/return_tracker.sv
// Return tracker
// holds each beat tag one stage so it meets the RAM read data, then
// loads the response register of the tagged port; all other ports see
// valid and done low in that cycle

`timescale 1ns/1ps
`default_nettype none

module return_tracker import memctrl_pkg::*; #(
	parameter int N_PORTS = 4
) (
	input  logic              gclk,
	input  logic              rst,
	input  beat_tag_t         beat_tag,
	input  logic [DATA_W-1:0] rdata,
	output mem_rsp_t          rsp [N_PORTS]
);

	// tag aligned with the RAM read cycle
	beat_tag_t          tag_d;
	// tagged port select
	logic [N_PORTS-1:0] hit;

	// --------------------------------------------------
	// delay stage
	// --------------------------------------------------
	always_ff @(posedge gclk) begin
		tag_d <= beat_tag;
		if (rst) begin
			tag_d.live <= 1'b0;
		end
	end

	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			hit[i] = tag_d.live && (tag_d.port == TAG_PORT_W'(i));
		end
	end

	// --------------------------------------------------
	// response registers
	// --------------------------------------------------
	always_ff @(posedge gclk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			// payload only moves for the owning port
			if (hit[i]) begin
				rsp[i].tid <= tag_d.tid;
				rsp[i].addr <= tag_d.addr;
				rsp[i].data <= rdata;
			end
			// strobes are one-cycle pulses
			if (rst) begin
				rsp[i].valid <= 1'b0;
				rsp[i].done <= 1'b0;
			end else begin
				rsp[i].valid <= hit[i] & tag_d.rd;
				rsp[i].done <= hit[i] & tag_d.done;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/blk_mem_ctrl.sv
// Block-RAM memory controller, top level
// N_PORTS refill ports with credit flow control share one RAM;
// per-port input buffers feed the burst scheduler, the RAM sits behind
// its input register and the return tracker drives the responses,
// three cycles after each beat is issued

`timescale 1ns/1ps
`default_nettype none

module blk_mem_ctrl import memctrl_pkg::*; #(
	parameter int N_PORTS = 4
) (
	input  logic               gclk,
	input  logic               rst,
	input  mem_cmd_t           cmd [N_PORTS],
	output logic [N_PORTS-1:0] credit,
	output mem_rsp_t           rsp [N_PORTS]
);

	mem_cmd_t           heads [N_PORTS];
	logic [N_PORTS-1:0] consume;
	ram_req_t           ram_req;
	beat_tag_t          beat_tag;
	logic [DATA_W-1:0]  rdata;

	// --------------------------------------------------
	// input buffers, one per port
	// --------------------------------------------------
	for (genvar i = 0; i < N_PORTS; i++) begin : g_port
		port_buffer u_buf (
			.gclk    (gclk),
			.rst     (rst),
			.cmd_in  (cmd[i]),
			.consume (consume[i]),
			.head    (heads[i])
		);
	end

	// arbitration and burst issue
	burst_scheduler #(.N_PORTS(N_PORTS)) u_sched (
		.gclk     (gclk),
		.rst      (rst),
		.heads    (heads),
		.consume  (consume),
		.credit   (credit),
		.ram_req  (ram_req),
		.beat_tag (beat_tag)
	);

	block_ram u_ram (
		.gclk  (gclk),
		.req   (ram_req),
		.rdata (rdata)
	);

	// tag delay and response registers
	return_tracker #(.N_PORTS(N_PORTS)) u_ret (
		.gclk     (gclk),
		.rst      (rst),
		.beat_tag (beat_tag),
		.rdata    (rdata),
		.rsp      (rsp)
	);

endmodule

`default_nettype wire

//--- verification/blk_mem_ctrl_tb.sv
// Block-RAM memory controller testbench
// four credit-counting requesters drive read and write blocks into the
// DUT, a shadow memory predicts read data, and a monitor checks every
// response, credit pulse and the round-robin order of done pulses

`timescale 1ns/1ps
`default_nettype none

module blk_mem_ctrl_tb import memctrl_pkg::*; ();

	localparam int N_PORTS = 4;
	localparam int SOLO_PORT = 2;
	// traffic phases
	localparam int MODE_IDLE = 0;
	localparam int MODE_MIXED = 1;
	localparam int MODE_RR = 2;
	localparam int MODE_SOLO = 3;

	logic               gclk;
	logic               rst;
	mem_cmd_t           cmd [N_PORTS];
	logic [N_PORTS-1:0] credit;
	mem_rsp_t           rsp [N_PORTS];

	// expected beats in send order
	mem_rsp_t          sent_q [N_PORTS][$];
	// beats waiting for their response cycle
	mem_rsp_t          pend_q [N_PORTS][$];
	int                due_q [N_PORTS][$];
	logic [BLK_W-1:0]  wr_blks [N_PORTS][$];
	logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
	int                credits_got [N_PORTS];
	int                cmds_sent [N_PORTS];
	int                blocks_sent [N_PORTS];
	int                target [N_PORTS];
	int                done_cnt [N_PORTS];
	bit                odd_due [N_PORTS];
	bit                we_cur [N_PORTS];
	logic [BLK_W-1:0]  blk_cur [N_PORTS];
	int                mode = MODE_IDLE;
	int                mode_seen = MODE_IDLE;
	int                last_done = -1;
	int                cycle = 0;
	int                errors = 0;
	int                checked = 0;

	blk_mem_ctrl #(.N_PORTS(N_PORTS)) uut (
		.gclk   (gclk),
		.rst    (rst),
		.cmd    (cmd),
		.credit (credit),
		.rsp    (rsp)
	);

	always #5 gclk = ~gclk;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// last word written or zero for untouched words
	function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return '0;
	endfunction

	function automatic logic [TID_W-1:0] port_tid(input int p);
		return TID_W'(16 + p);
	endfunction

	task automatic report_mismatch(input int p, input string field,
			input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want);
		errors++;
		$display("ERROR t=%0t rsp[%0d].%s got %0h exp %0h", $time, p, field, got, want);
	endtask

	// tid and addr only matter with a strobe and data only on a read
	task automatic check_rsp(input int p, input mem_rsp_t got, input mem_rsp_t want);
		if (got.valid !== want.valid)
			report_mismatch(p, "valid", got.valid, want.valid);
		if (got.done !== want.done)
			report_mismatch(p, "done", got.done, want.done);
		if (want.valid || want.done) begin
			if (got.tid !== want.tid)
				report_mismatch(p, "tid", got.tid, want.tid);
			if (got.addr !== want.addr)
				report_mismatch(p, "addr", got.addr, want.addr);
		end
		if (want.valid && got.data !== want.data)
			report_mismatch(p, "data", got.data, want.data);
	endtask

	task automatic check_credit(input int p, input int got, input int want);
		if (got != want) begin
			errors++;
			$display("ERROR t=%0t credit count port %0d got %0d exp %0d", $time, p, got, want);
		end
	endtask

	// --------------------------------------------------
	// requesters
	// --------------------------------------------------
	// first block of a port is always a write so reads hit known words
	task automatic pick_block(input int p);
		if (mode == MODE_MIXED && (wr_blks[p].size() == 0 || $urandom_range(1, 0) == 1)) begin
			we_cur[p] = 1'b1;
			blk_cur[p] = BLK_W'(p * 64 + $urandom_range(15, 0));
			wr_blks[p].push_back(blk_cur[p]);
		end else begin
			we_cur[p] = 1'b0;
			blk_cur[p] = wr_blks[p][$urandom_range(wr_blks[p].size() - 1, 0)];
		end
	endtask

	task automatic send_word(input int p, input logic odd);
		mem_cmd_t c;
		mem_rsp_t want;
		logic [ADDR_W-1:0] a;
		a = {blk_cur[p], odd};
		c.valid = 1'b1;
		c.we = we_cur[p];
		c.tid = port_tid(p);
		c.blk = blk_cur[p];
		c.data = {$urandom, $urandom};
		want = '0;
		want.done = odd;
		want.tid = c.tid;
		want.addr = a;
		// read data is fixed by command order within the port
		if (c.we) begin
			shadow[a] = c.data;
		end else begin
			want.valid = 1'b1;
			want.data = ref_read(a);
		end
		sent_q[p].push_back(want);
		cmds_sent[p]++;
		cmd[p] = c;
		odd_due[p] = !odd;
		if (odd)
			blocks_sent[p]++;
	endtask

	always @(negedge gclk) begin
		int avail;
		for (int p = 0; p < N_PORTS; p++) begin
			cmd[p] = '0;
			avail = 2 + credits_got[p] - cmds_sent[p];
			if (rst) begin
				odd_due[p] = 1'b0;
			end else if (odd_due[p]) begin
				send_word(p, 1'b1);
			end else if (mode != MODE_IDLE && blocks_sent[p] < target[p] && avail >= 2) begin
				pick_block(p);
				send_word(p, 1'b0);
			end
		end
	end

	// --------------------------------------------------
	// monitor
	// --------------------------------------------------
	// registered outputs sampled at the edge before they update
	always @(posedge gclk) begin
		mem_rsp_t want;
		cycle++;
		if (!rst) begin
			if (mode != mode_seen) begin
				mode_seen = mode;
				last_done = -1;
			end
			for (int p = 0; p < N_PORTS; p++) begin
				want = '0;
				if (pend_q[p].size() > 0 && due_q[p][0] == cycle) begin
					want = pend_q[p].pop_front();
					void'(due_q[p].pop_front());
				end
				check_rsp(p, rsp[p], want);
				if (want.valid || want.done)
					checked++;
				// strict done rotation with all ports loaded
				if (rsp[p].done === 1'b1) begin
					done_cnt[p]++;
					if (mode == MODE_RR && last_done >= 0 && p != (last_done + 1) % N_PORTS) begin
						errors++;
						$display("ERROR t=%0t done port got %0d exp %0d", $time, p,
							(last_done + 1) % N_PORTS);
					end
					if (mode == MODE_RR)
						last_done = p;
					if (mode == MODE_SOLO && p != SOLO_PORT) begin
						errors++;
						$display("port %0d signalled done while only port %0d was active",
							p, SOLO_PORT);
					end
				end
				// response is due two cycles after the credit pulse
				if (credit[p] === 1'b1) begin
					credits_got[p]++;
					if (sent_q[p].size() == 0) begin
						errors++;
						$display("credit pulse on port %0d with no command outstanding", p);
					end else begin
						pend_q[p].push_back(sent_q[p].pop_front());
						due_q[p].push_back(cycle + 2);
					end
					if (2 + credits_got[p] - cmds_sent[p] > 2) begin
						errors++;
						$display("credit count of port %0d rose above 2", p);
					end
				end else if (credit[p] !== 1'b0) begin
					errors++;
					$display("credit bit of port %0d is unknown", p);
				end
			end
		end
	end

	// --------------------------------------------------
	// sequence
	// --------------------------------------------------
	task automatic wait_drain(input int limit);
		int waited;
		bit busy;
		burst_state_e st;
		waited = 0;
		busy = 1'b1;
		while (busy) begin
			@(negedge gclk);
			waited++;
			busy = 1'b0;
			for (int p = 0; p < N_PORTS; p++) begin
				if (blocks_sent[p] < target[p] || odd_due[p] ||
						sent_q[p].size() > 0 || pend_q[p].size() > 0)
					busy = 1'b1;
			end
			if (busy && waited > limit) begin
				st = uut.u_sched.state;
				errors++;
				$display("timeout: ports did not drain within %0d cycles, scheduler in %s",
					limit, st.name());
				$display("summary: %0d responses checked, %0d errors", checked, errors);
				$display("Finished with errors");
				$finish;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h4319_ce63));
		gclk = 1'b0;
		rst = 1'b1;
		for (int p = 0; p < N_PORTS; p++)
			cmd[p] = '0;
		repeat (3) @(posedge gclk);
		@(negedge gclk);
		rst = 1'b0;
		// quiet window with no strobes or credit expected
		repeat (6) @(posedge gclk);
		mode = MODE_MIXED;
		for (int p = 0; p < N_PORTS; p++)
			target[p] = 12;
		wait_drain(2000);
		@(posedge gclk);
		mode = MODE_RR;
		for (int p = 0; p < N_PORTS; p++)
			target[p] += 10;
		wait_drain(2000);
		@(posedge gclk);
		mode = MODE_SOLO;
		target[SOLO_PORT] += 8;
		wait_drain(1000);
		// every credit back and one done per block
		for (int p = 0; p < N_PORTS; p++) begin
			check_credit(p, 2 + credits_got[p] - cmds_sent[p], 2);
			if (done_cnt[p] != blocks_sent[p]) begin
				errors++;
				$display("ERROR t=%0t done count port %0d got %0d exp %0d", $time, p,
					done_cnt[p], blocks_sent[p]);
			end
		end
		$display("summary: %0d responses checked, %0d errors", checked, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
design/memctrl_pkg.sv
design/port_buffer.sv
design/burst_scheduler.sv
design/block_ram.sv
design/return_tracker.sv
design/blk_mem_ctrl.sv
verification/blk_mem_ctrl_tb.sv

//--- Bender.yml
package:
  name: blk_mem_ctrl

sources:
  - files:
      - design/memctrl_pkg.sv
      - design/port_buffer.sv
      - design/burst_scheduler.sv
      - design/block_ram.sv
      - design/return_tracker.sv
      - design/blk_mem_ctrl.sv
  - target: test
    files:
      - verification/blk_mem_ctrl_tb.sv
